/* tb/dispatch_input.txt */
# D pc(hex) lrd prd old_prd need_to_wb prs1 prs2 src1_is_reg src2_is_reg alu_type wb_delay
# F = flush pulse and walk, W = wait until the ROB is empty
D 1000 1 10 1 1 0 0 0 0 0 4
D 1004 2 11 2 1 0 0 0 0 1 1
D 1008 3 12 3 1 10 11 1 1 0 2
D 100c 4 13 4 1 12 0 1 0 2 1
D 1010 0 0 0 0 13 12 1 1 3 1
W
D 2000 5 20 5 1 0 0 0 0 0 20
D 2004 6 21 6 1 20 0 1 0 1 3
D 2008 7 22 7 1 20 0 1 0 4 1
D 200c 8 23 8 1 0 20 0 1 5 2
D 2010 9 24 9 1 20 20 1 1 0 1
D 2014 10 25 10 1 20 0 1 0 7 3
D 2018 11 26 11 1 20 0 1 0 8 1
D 201c 12 27 12 1 20 0 1 0 9 2
D 2020 13 28 13 1 20 0 1 0 10 1
D 2024 14 29 14 1 20 0 1 0 6 1
W
D 3000 6 30 21 1 0 0 0 0 0 30
D 3004 7 31 22 1 30 0 1 0 1 1
D 3008 8 32 23 1 0 0 0 0 4 1
D 300c 9 33 24 1 31 32 1 1 0 1
F
D 4000 6 30 21 1 0 0 0 0 0 2
D 4004 7 31 22 1 30 0 1 0 1 1
W

/* sources.f */
+incdir+source
source/uop_pkg.sv
source/rob_pkg.sv
source/dispatch.sv
source/busy_table.sv
source/rob.sv
source/int_issue_queue.sv
source/backend_top.sv
tb/backend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module backend_tb -o backend_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/backend_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
fi

if grep -q "^TESTS PASSED$" sim.log; then
    exit 0
fi
exit 1

/* tb/backend_tb.sv */
`timescale 1ns/100ps
`include "backend_macros.svh"

module backend_tb;

    import rob_pkg::*;

    logic                       clock;
    logic                       rst_n;
    logic                       instr_valid;
    logic                       instr_ready;
    logic [`PC_RANGE]           pc;
    logic [`LREG_RANGE]         lrd;
    logic [`PREG_RANGE]         prd;
    logic [`PREG_RANGE]         old_prd;
    logic                       need_to_wb;
    logic [`PREG_RANGE]         prs1;
    logic [`PREG_RANGE]         prs2;
    logic                       src1_is_reg;
    logic                       src2_is_reg;
    logic [63:0]                imm;
    uop_pkg::alu_type_e         alu_type;
    uop_pkg::cx_type_e          cx_type;
    uop_pkg::muldiv_type_e      muldiv_type;
    logic                       wb_valid;
    logic [`INSTR_ID_WIDTH-1:0] wb_robid;
    logic [`PREG_RANGE]         wb_prd;
    logic                       wb_need_to_wb;
    logic                       flush_valid;
    logic                       issue_valid;
    logic [`INSTR_ID_WIDTH-1:0] issue_robid;
    logic [`PREG_RANGE]         issue_prd;
    logic [`PC_RANGE]           issue_pc;
    uop_pkg::alu_type_e         issue_alu_type;
    logic                       commit_valid;
    logic [`LREG_RANGE]         commit_lrd;
    logic [`PREG_RANGE]         commit_prd;
    logic [`PREG_RANGE]         commit_old_prd;
    logic [`PC_RANGE]           commit_pc;
    logic                       walk_valid;
    logic [`LREG_RANGE]         walk_lrd;
    logic [`PREG_RANGE]         walk_prd;
    logic [`PREG_RANGE]         walk_old_prd;

    // model of in-flight instructions, indexed by rob id
    logic [63:0] e_pc [`ROB_DEPTH];
    int          e_lrd [`ROB_DEPTH];
    int          e_prd [`ROB_DEPTH];
    int          e_old [`ROB_DEPTH];
    int          e_need [`ROB_DEPTH];
    int          e_prs1 [`ROB_DEPTH];
    int          e_prs2 [`ROB_DEPTH];
    int          e_r1 [`ROB_DEPTH];
    int          e_r2 [`ROB_DEPTH];
    int          e_alu [`ROB_DEPTH];
    int          e_delay [`ROB_DEPTH];
    bit          e_issued [`ROB_DEPTH];
    bit          e_done [`ROB_DEPTH];
    bit          tb_busy [`PREG_NUM];
    int          rob_q [$];         // program order, oldest first
    int          pend_id [$];
    int          pend_due [$];
    int          tb_tail;
    int          cyc;
    int          cur_delay;
    bit          last_xfer;
    bit          saw_full;
    bit          saw_walk;

    backend_top dut_i (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %0h expected %0h", $time, name, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic abort_run(string why);
        $display("error at t=%0t: %s", $time, why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    function automatic bit srcs_ready(int j);
        return !(e_r1[j] != 0 && tb_busy[e_prs1[j]]) && !(e_r2[j] != 0 && tb_busy[e_prs2[j]]);
    endfunction

    task automatic check_issue(int id);
        int pos;
        pos = -1;
        foreach (rob_q[k]) begin
            if (rob_q[k] == id) pos = k;
        end
        if (pos < 0 || e_issued[id]) abort_run("issued an instruction that is not waiting");
        check_value("issue src ready", srcs_ready(id), 1);
        for (int k = 0; k < pos; k++) begin
            if (!e_issued[rob_q[k]] && srcs_ready(rob_q[k]))
                abort_run("younger instruction issued ahead of a ready older one");
        end
        check_value("issue_pc", issue_pc, e_pc[id]);
        check_value("issue_prd", issue_prd, e_prd[id]);
        check_value("issue_alu_type", issue_alu_type, e_alu[id]);
        e_issued[id] = 1'b1;
        pend_id.push_back(id);
        pend_due.push_back(cyc + e_delay[id] + int'($urandom % 3));   // jitter the fu latency
    endtask

    always @(posedge clock) begin
        int id;
        int waiting;
        int hit;
        cyc++;
        last_xfer = 1'b0;
        if (rst_n) begin
            waiting = 0;
            foreach (rob_q[k]) begin
                if (!e_issued[rob_q[k]]) waiting++;
            end
            if (waiting == `ISQ_DEPTH) begin
                check_value("instr_ready (isq full)", instr_ready, 0);
                saw_full = 1'b1;
            end
            if (dut_i.rob_state == ROB_WALK) check_value("instr_ready (walk)", instr_ready, 0);
            if (issue_valid && !flush_valid) check_issue(issue_robid);
            if (commit_valid) begin
                if (rob_q.size() == 0) abort_run("commit with an empty ROB");
                id = rob_q.pop_front();
                check_value("commit done", e_done[id], 1);
                check_value("commit_pc", commit_pc, e_pc[id]);
                check_value("commit_lrd", commit_lrd, e_lrd[id]);
                check_value("commit_prd", commit_prd, e_prd[id]);
                check_value("commit_old_prd", commit_old_prd, e_old[id]);
            end
            if (walk_valid) begin
                if (rob_q.size() == 0) abort_run("walk with an empty ROB");
                id = rob_q.pop_back();  // youngest first
                check_value("walk_lrd", walk_lrd, e_lrd[id]);
                check_value("walk_prd", walk_prd, e_prd[id]);
                check_value("walk_old_prd", walk_old_prd, e_old[id]);
                if (e_need[id] != 0) tb_busy[e_prd[id]] = 1'b0;
                tb_tail = (tb_tail + `ROB_DEPTH - 1) % `ROB_DEPTH;
                saw_walk = 1'b1;
            end
            if (wb_valid) begin
                e_done[wb_robid] = 1'b1;
                if (wb_need_to_wb) tb_busy[wb_prd] = 1'b0;
            end
            if (instr_valid && instr_ready) begin
                id = tb_tail;
                e_pc[id] = pc;
                e_lrd[id] = lrd;
                e_prd[id] = prd;
                e_old[id] = old_prd;
                e_need[id] = need_to_wb;
                e_prs1[id] = prs1;
                e_prs2[id] = prs2;
                e_r1[id] = src1_is_reg;
                e_r2[id] = src2_is_reg;
                e_alu[id] = alu_type;
                e_delay[id] = cur_delay;
                e_issued[id] = 1'b0;
                e_done[id] = 1'b0;
                if (need_to_wb && prd != 0) tb_busy[prd] = 1'b1;
                rob_q.push_back(id);
                tb_tail = (tb_tail + 1) % `ROB_DEPTH;
                last_xfer = 1'b1;
            end
            if (flush_valid) begin  // flushed work never writes back
                pend_id.delete();
                pend_due.delete();
            end
        end
        #1;
        wb_valid = 1'b0;
        hit = -1;
        foreach (pend_id[k]) begin
            if (hit < 0 && pend_due[k] <= cyc) hit = k;
        end
        if (hit >= 0) begin
            id = pend_id[hit];
            wb_valid = 1'b1;
            wb_robid = id;
            wb_prd = e_prd[id];
            wb_need_to_wb = e_need[id];
            pend_id.delete(hit);
            pend_due.delete(hit);
        end
    end

    task automatic send_instr(logic [63:0] f_pc, int f[10]);
        int t;
        pc = f_pc;
        lrd = f[0];
        prd = f[1];
        old_prd = f[2];
        need_to_wb = f[3];
        prs1 = f[4];
        prs2 = f[5];
        src1_is_reg = f[6];
        src2_is_reg = f[7];
        alu_type = uop_pkg::alu_type_e'(f[8]);
        cur_delay = f[9];
        instr_valid = 1'b1;
        t = 0;
        do begin
            @(posedge clock);
            #1;
            t++;
            if (t > 300) abort_run("timeout waiting for dispatch to accept an instruction");
        end while (!last_xfer);
        instr_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (rob_q.size() != 0) begin
            @(posedge clock);
            #1;
            t++;
            if (t > 500) abort_run("timeout waiting for the ROB to drain");
        end
    endtask

    task automatic flush_and_walk();
        int t;
        flush_valid = 1'b1;
        @(posedge clock);
        #1;
        flush_valid = 1'b0;
        t = 0;
        while (rob_q.size() != 0 || dut_i.rob_state != ROB_IDLE) begin
            @(posedge clock);
            #1;
            t++;
            if (t > 100) abort_run("timeout waiting for the flush walk to finish");
        end
        check_value("instr_ready (after walk)", instr_ready, 1);
    endtask

    initial begin
        int fd;
        int code;
        string line;
        string cmd;
        logic [63:0] f_pc;
        int f[10];
        void'($urandom(28));
        rst_n = 1'b0;
        instr_valid = 1'b0;
        pc = '0;
        lrd = '0;
        prd = '0;
        old_prd = '0;
        need_to_wb = 1'b0;
        prs1 = '0;
        prs2 = '0;
        src1_is_reg = 1'b0;
        src2_is_reg = 1'b0;
        imm = '0;
        alu_type = uop_pkg::ALU_ADD;
        cx_type = uop_pkg::CX_NONE;
        muldiv_type = uop_pkg::MD_NONE;
        wb_valid = 1'b0;
        wb_robid = '0;
        wb_prd = '0;
        wb_need_to_wb = 1'b0;
        flush_valid = 1'b0;
        fd = $fopen("tb/dispatch_input.txt", "r");
        if (fd == 0) abort_run("cannot open tb/dispatch_input.txt");
        repeat (8) @(posedge clock);
        #1;
        rst_n = 1'b1;
        check_value("issue_valid", issue_valid, 0);
        check_value("commit_valid", commit_valid, 0);
        check_value("walk_valid", walk_valid, 0);
        check_value("instr_ready", instr_ready, 1);
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 1 && line.substr(0, 0) != "#") begin
                code = $sscanf(line, "%s", cmd);
                if (cmd == "D") begin
                    code = $sscanf(line, "%s %h %d %d %d %d %d %d %d %d %d %d", cmd, f_pc,
                                   f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
                    if (code != 12) abort_run("malformed dispatch line in input file");
                    send_instr(f_pc, f);
                end else if (cmd == "F") begin
                    flush_and_walk();
                end else if (cmd == "W") begin
                    wait_drained();
                end else begin
                    abort_run("unknown command in input file");
                end
            end
        end
        $fclose(fd);
        wait_drained();
        check_value("isq full seen", saw_full, 1);
        check_value("walk seen", saw_walk, 1);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* source/backend_top.sv */
`timescale 1ns/100ps
`include "backend_macros.svh"

module backend_top (
    input  logic                       clock,
    input  logic                       rst_n,
    // rename
    input  logic                       instr_valid,
    output logic                       instr_ready,
    input  logic [`PC_RANGE]           pc,
    input  logic [`LREG_RANGE]         lrd,
    input  logic [`PREG_RANGE]         prd,
    input  logic [`PREG_RANGE]         old_prd,
    input  logic                       need_to_wb,
    input  logic [`PREG_RANGE]         prs1,
    input  logic [`PREG_RANGE]         prs2,
    input  logic                       src1_is_reg,
    input  logic                       src2_is_reg,
    input  logic [63:0]                imm,
    input  uop_pkg::alu_type_e         alu_type,
    input  uop_pkg::cx_type_e          cx_type,
    input  uop_pkg::muldiv_type_e      muldiv_type,
    // writeback from the functional unit
    input  logic                       wb_valid,
    input  logic [`INSTR_ID_WIDTH-1:0] wb_robid,
    input  logic [`PREG_RANGE]         wb_prd,
    input  logic                       wb_need_to_wb,
    input  logic                       flush_valid,
    // issue
    output logic                       issue_valid,
    output logic [`INSTR_ID_WIDTH-1:0] issue_robid,
    output logic [`PREG_RANGE]         issue_prd,
    output logic [`PC_RANGE]           issue_pc,
    output uop_pkg::alu_type_e         issue_alu_type,
    // commit and walk
    output logic                       commit_valid,
    output logic [`LREG_RANGE]         commit_lrd,
    output logic [`PREG_RANGE]         commit_prd,
    output logic [`PREG_RANGE]         commit_old_prd,
    output logic [`PC_RANGE]           commit_pc,
    output logic                       walk_valid,
    output logic [`LREG_RANGE]         walk_lrd,
    output logic [`PREG_RANGE]         walk_prd,
    output logic [`PREG_RANGE]         walk_old_prd
);

    import uop_pkg::*;
    import rob_pkg::*;

    // dispatch to rob
    logic                       rob_enq_valid;
    logic [`PC_RANGE]           rob_pc;
    logic [`LREG_RANGE]         rob_lrd;
    logic [`PREG_RANGE]         rob_prd;
    logic [`PREG_RANGE]         rob_old_prd;
    logic                       rob_need_to_wb;
    logic                       rob_can_enq;
    logic [`INSTR_ID_WIDTH-1:0] rob_enq_id;
    rob_state_e                 rob_state;
    // dispatch to issue queue
    logic                       isq_can_alloc;
    logic                       isq_enq_valid;
    logic [`PC_RANGE]           isq_pc;
    logic [63:0]                isq_imm;
    logic [`PREG_RANGE]         isq_prd;
    logic [`PREG_RANGE]         isq_prs1;
    logic [`PREG_RANGE]         isq_prs2;
    alu_type_e                  isq_alu_type;
    cx_type_e                   isq_cx_type;
    muldiv_type_e               isq_muldiv_type;
    logic [`INSTR_ID_WIDTH-1:0] isq_robid;
    logic                       isq_src1_state;
    logic                       isq_src2_state;
    // dispatch to busy table
    logic [`PREG_RANGE]         rd_prs1;
    logic [`PREG_RANGE]         rd_prs2;
    logic                       src1_busy;
    logic                       src2_busy;
    logic                       alloc_en;
    logic [`PREG_RANGE]         alloc_prd;

    dispatch dispatch_i (.*);

    busy_table busy_table_i (.*);

    rob rob_i (
        .*,
        .enq_valid      (rob_enq_valid),
        .enq_pc         (rob_pc),
        .enq_lrd        (rob_lrd),
        .enq_prd        (rob_prd),
        .enq_old_prd    (rob_old_prd),
        .enq_need_to_wb (rob_need_to_wb),
        .can_enq        (rob_can_enq),
        .enq_id         (rob_enq_id)
    );

    int_issue_queue int_issue_queue_i (
        .*,
        .enq_valid   (isq_enq_valid),
        .pc          (isq_pc),
        .imm         (isq_imm),
        .prd         (isq_prd),
        .prs1        (isq_prs1),
        .prs2        (isq_prs2),
        .alu_type    (isq_alu_type),
        .cx_type     (isq_cx_type),
        .muldiv_type (isq_muldiv_type),
        .robid       (isq_robid),
        .src1_state  (isq_src1_state),
        .src2_state  (isq_src2_state),
        .can_alloc   (isq_can_alloc)
    );

endmodule

/* source/int_issue_queue.sv */
`timescale 1ns/100ps
`include "backend_macros.svh"

module int_issue_queue (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enq_valid,
    input  logic [`PC_RANGE]           pc,
    input  logic [63:0]                imm,
    input  logic [`PREG_RANGE]         prd,
    input  logic [`PREG_RANGE]         prs1,
    input  logic [`PREG_RANGE]         prs2,
    input  uop_pkg::alu_type_e         alu_type,
    input  uop_pkg::cx_type_e          cx_type,
    input  uop_pkg::muldiv_type_e      muldiv_type,
    input  logic [`INSTR_ID_WIDTH-1:0] robid,
    input  logic                       src1_state,
    input  logic                       src2_state,
    input  logic                       wb_valid,
    input  logic                       wb_need_to_wb,
    input  logic [`PREG_RANGE]         wb_prd,
    input  logic                       flush_valid,
    output logic                       can_alloc,
    output logic                       issue_valid,
    output logic [`INSTR_ID_WIDTH-1:0] issue_robid,
    output logic [`PREG_RANGE]         issue_prd,
    output logic [`PC_RANGE]           issue_pc,
    output uop_pkg::alu_type_e         issue_alu_type
);

    import uop_pkg::*;

    localparam int IDXW = $clog2(`ISQ_DEPTH);

    logic [`ISQ_DEPTH-1:0]      valid;
    logic [`ISQ_DEPTH-1:0]      sleep1;
    logic [`ISQ_DEPTH-1:0]      sleep2;
    logic [`ISQ_DEPTH-1:0]      ready;
    logic [IDXW-1:0]            age       [`ISQ_DEPTH];   // younger entries still waiting
    logic [`PC_RANGE]           ent_pc    [`ISQ_DEPTH];
    logic [`PREG_RANGE]         ent_prd   [`ISQ_DEPTH];
    logic [`PREG_RANGE]         ent_prs1  [`ISQ_DEPTH];
    logic [`PREG_RANGE]         ent_prs2  [`ISQ_DEPTH];
    logic [`INSTR_ID_WIDTH-1:0] ent_robid [`ISQ_DEPTH];
    alu_type_e                  ent_alu   [`ISQ_DEPTH];
    logic [IDXW-1:0]            free_idx;
    logic [IDXW-1:0]            sel;
    logic                       wb_hit;

    assign wb_hit    = wb_valid && wb_need_to_wb;
    assign can_alloc = ~&valid;
    assign ready     = valid & ~sleep1 & ~sleep2;

    always_comb begin
        free_idx = '0;
        for (int i = `ISQ_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = IDXW'(i);     // lowest free slot
        end
    end

    // oldest ready entry has the most younger ones behind it
    always_comb begin
        issue_valid = 1'b0;
        sel         = '0;
        for (int i = 0; i < `ISQ_DEPTH; i++) begin
            if (ready[i] && (!issue_valid || age[i] > age[sel])) begin
                issue_valid = 1'b1;
                sel         = IDXW'(i);
            end
        end
    end

    assign issue_robid    = ent_robid[sel];
    assign issue_prd      = ent_prd[sel];
    assign issue_pc       = ent_pc[sel];
    assign issue_alu_type = ent_alu[sel];

    always_ff @(posedge clock) begin
        if (!rst_n || flush_valid) begin
            valid <= '0;
        end else begin
            if (issue_valid) begin
                valid[sel] <= 1'b0;
            end
            if (enq_valid) begin
                valid[free_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < `ISQ_DEPTH; i++) begin
            age[i] <= age[i] + IDXW'(enq_valid) - IDXW'(issue_valid && age[i] > age[sel]);
            if (wb_hit && ent_prs1[i] == wb_prd) begin
                sleep1[i] <= 1'b0;      // wakeup
            end
            if (wb_hit && ent_prs2[i] == wb_prd) begin
                sleep2[i] <= 1'b0;
            end
        end
        if (enq_valid) begin
            age[free_idx]       <= '0;
            sleep1[free_idx]    <= src1_state && !(wb_hit && prs1 == wb_prd);
            sleep2[free_idx]    <= src2_state && !(wb_hit && prs2 == wb_prd);
            ent_pc[free_idx]    <= pc;
            ent_prd[free_idx]   <= prd;
            ent_prs1[free_idx]  <= prs1;
            ent_prs2[free_idx]  <= prs2;
            ent_robid[free_idx] <= robid;
            ent_alu[free_idx]   <= alu_type;
        end
    end

    // an entry leaves on its single issue, so one instruction never issues twice running
    assert property (@(posedge clock) disable iff (!rst_n)
        issue_valid |=> !(issue_valid && issue_robid == $past(issue_robid)));

endmodule

/* source/rob.sv */
`timescale 1ns/100ps
`include "backend_macros.svh"

module rob (
    input  logic                       clock,
    input  logic                       rst_n,
    input  logic                       enq_valid,
    input  logic [`PC_RANGE]           enq_pc,
    input  logic [`LREG_RANGE]         enq_lrd,
    input  logic [`PREG_RANGE]         enq_prd,
    input  logic [`PREG_RANGE]         enq_old_prd,
    input  logic                       enq_need_to_wb,
    input  logic                       wb_valid,
    input  logic [`INSTR_ID_WIDTH-1:0] wb_robid,
    input  logic                       flush_valid,
    output logic                       can_enq,
    output logic [`INSTR_ID_WIDTH-1:0] enq_id,
    output rob_pkg::rob_state_e        rob_state,
    output logic                       commit_valid,
    output logic [`LREG_RANGE]         commit_lrd,
    output logic [`PREG_RANGE]         commit_prd,
    output logic [`PREG_RANGE]         commit_old_prd,
    output logic [`PC_RANGE]           commit_pc,
    output logic                       walk_valid,
    output logic [`LREG_RANGE]         walk_lrd,
    output logic [`PREG_RANGE]         walk_prd,
    output logic [`PREG_RANGE]         walk_old_prd
);

    import rob_pkg::*;

    localparam int IDW = `INSTR_ID_WIDTH;
    localparam int CW  = IDW + 1;

    logic [`PC_RANGE]        ent_pc      [`ROB_DEPTH];
    logic [`LREG_RANGE]      ent_lrd     [`ROB_DEPTH];
    logic [`PREG_RANGE]      ent_prd     [`ROB_DEPTH];
    logic [`PREG_RANGE]      ent_old_prd [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]   complete;
    logic [IDW-1:0]          head;
    logic [IDW-1:0]          tail;
    logic [IDW-1:0]          last;          // youngest entry
    logic [IDW-1:0]          wb_ofs;
    logic [CW-1:0]           count;

    assign can_enq = count != CW'(`ROB_DEPTH);
    assign enq_id  = tail;
    assign last    = tail - 1'b1;
    assign wb_ofs  = wb_robid - head;

    // no commit in the flush cycle, everything left goes to the walk
    assign commit_valid   = rob_state == ROB_IDLE && count != '0 && complete[head] && !flush_valid;
    assign commit_lrd     = ent_lrd[head];
    assign commit_prd     = ent_prd[head];
    assign commit_old_prd = ent_old_prd[head];
    assign commit_pc      = ent_pc[head];

    assign walk_valid   = rob_state == ROB_WALK && count != '0;
    assign walk_lrd     = ent_lrd[last];
    assign walk_prd     = ent_prd[last];
    assign walk_old_prd = ent_old_prd[last];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rob_state <= ROB_IDLE;
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            complete  <= '0;
        end else if (rob_state == ROB_IDLE) begin
            if (enq_valid) begin
                tail           <= tail + 1'b1;
                complete[tail] <= 1'b0;
            end
            if (wb_valid) begin
                complete[wb_robid] <= 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
            end
            count <= count + CW'(enq_valid) - CW'(commit_valid);
            if (flush_valid) begin
                rob_state <= ROB_WALK;
            end
        end else begin
            if (walk_valid) begin       // pop from the tail, writebacks ignored
                tail  <= last;
                count <= count - 1'b1;
            end
            if (count <= CW'(1)) begin
                rob_state <= ROB_IDLE;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq_valid) begin
            ent_pc[tail]      <= enq_pc;
            ent_lrd[tail]     <= enq_lrd;
            ent_prd[tail]     <= enq_need_to_wb ? enq_prd : '0;   // p0 when no destination
            ent_old_prd[tail] <= enq_old_prd;
        end
    end

    // a writeback must belong to an instruction dispatched and not yet committed
    assert property (@(posedge clock) disable iff (!rst_n)
        wb_valid && rob_state == ROB_IDLE |-> {1'b0, wb_ofs} < count);

endmodule

/* source/busy_table.sv */
`timescale 1ns/100ps
`include "backend_macros.svh"

module busy_table (
    input  logic               clock,
    input  logic               rst_n,
    input  logic [`PREG_RANGE] rd_prs1,
    input  logic [`PREG_RANGE] rd_prs2,
    input  logic               alloc_en,
    input  logic [`PREG_RANGE] alloc_prd,
    input  logic               wb_valid,
    input  logic               wb_need_to_wb,
    input  logic [`PREG_RANGE] wb_prd,
    input  logic               walk_valid,
    input  logic [`PREG_RANGE] walk_prd,
    output logic               src1_busy,
    output logic               src2_busy
);

    logic [`PREG_NUM-1:0] busy;
    logic                 wb_clr;

    assign wb_clr = wb_valid && wb_need_to_wb;

    // same-cycle writeback bypasses the stored bit
    assign src1_busy = busy[rd_prs1] && !(wb_clr && wb_prd == rd_prs1);
    assign src2_busy = busy[rd_prs2] && !(wb_clr && wb_prd == rd_prs2);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            if (wb_clr) begin
                busy[wb_prd] <= 1'b0;
            end
            if (walk_valid) begin
                busy[walk_prd] <= 1'b0;     // rolled-back destination is free again
            end
            if (alloc_en && alloc_prd != '0) begin
                busy[alloc_prd] <= 1'b1;    // p0 stays ready
            end
        end
    end

    // rename hands out a prd only after its previous value was written back or walked
    assert property (@(posedge clock) disable iff (!rst_n)
        alloc_en && alloc_prd != '0 |-> !busy[alloc_prd]);

endmodule

/* source/dispatch.sv */
`timescale 1ns/100ps
`include "backend_macros.svh"

module dispatch (
    input  logic                       clock,
    input  logic                       rst_n,
    // from rename
    input  logic                       instr_valid,
    output logic                       instr_ready,
    input  logic [`PC_RANGE]           pc,
    input  logic [`LREG_RANGE]         lrd,
    input  logic [`PREG_RANGE]         prd,
    input  logic [`PREG_RANGE]         old_prd,
    input  logic                       need_to_wb,
    input  logic [`PREG_RANGE]         prs1,
    input  logic [`PREG_RANGE]         prs2,
    input  logic                       src1_is_reg,
    input  logic                       src2_is_reg,
    input  logic [63:0]                imm,
    input  uop_pkg::alu_type_e         alu_type,
    input  uop_pkg::cx_type_e          cx_type,
    input  uop_pkg::muldiv_type_e      muldiv_type,
    // rob
    input  logic                       rob_can_enq,
    input  logic [`INSTR_ID_WIDTH-1:0] rob_enq_id,
    input  rob_pkg::rob_state_e        rob_state,
    output logic                       rob_enq_valid,
    output logic [`PC_RANGE]           rob_pc,
    output logic [`LREG_RANGE]         rob_lrd,
    output logic [`PREG_RANGE]         rob_prd,
    output logic [`PREG_RANGE]         rob_old_prd,
    output logic                       rob_need_to_wb,
    // integer issue queue
    input  logic                       isq_can_alloc,
    output logic                       isq_enq_valid,
    output logic [`PC_RANGE]           isq_pc,
    output logic [63:0]                isq_imm,
    output logic [`PREG_RANGE]         isq_prd,
    output logic [`PREG_RANGE]         isq_prs1,
    output logic [`PREG_RANGE]         isq_prs2,
    output uop_pkg::alu_type_e         isq_alu_type,
    output uop_pkg::cx_type_e          isq_cx_type,
    output uop_pkg::muldiv_type_e      isq_muldiv_type,
    output logic [`INSTR_ID_WIDTH-1:0] isq_robid,
    output logic                       isq_src1_state,
    output logic                       isq_src2_state,
    // busy table
    output logic [`PREG_RANGE]         rd_prs1,
    output logic [`PREG_RANGE]         rd_prs2,
    input  logic                       src1_busy,
    input  logic                       src2_busy,
    output logic                       alloc_en,
    output logic [`PREG_RANGE]         alloc_prd,
    input  logic                       flush_valid
);

    import rob_pkg::*;

    logic enq_fire;

    assign instr_ready = rob_can_enq && isq_can_alloc && !flush_valid && rob_state == ROB_IDLE;
    assign enq_fire    = instr_valid && instr_ready;

    // rob and issue queue take the instruction in the same cycle
    assign rob_enq_valid  = enq_fire;
    assign rob_pc         = pc;
    assign rob_lrd        = lrd;
    assign rob_prd        = prd;
    assign rob_old_prd    = old_prd;
    assign rob_need_to_wb = need_to_wb;

    assign isq_enq_valid   = enq_fire;
    assign isq_pc          = pc;
    assign isq_imm         = imm;
    assign isq_prd         = prd;
    assign isq_prs1        = prs1;
    assign isq_prs2        = prs2;
    assign isq_alu_type    = alu_type;
    assign isq_cx_type     = cx_type;
    assign isq_muldiv_type = muldiv_type;
    assign isq_robid       = rob_enq_id;       // slot the rob is about to fill

    assign rd_prs1        = prs1;
    assign rd_prs2        = prs2;
    assign isq_src1_state = src1_is_reg && src1_busy;   // 1 = asleep
    assign isq_src2_state = src2_is_reg && src2_busy;

    assign alloc_en  = enq_fire && need_to_wb;
    assign alloc_prd = prd;

    // the rob walk takes over the stall right after a flush
    assert property (@(posedge clock) disable iff (!rst_n)
        flush_valid && rob_state == ROB_IDLE |=> rob_state == ROB_WALK);

endmodule

/* source/rob_pkg.sv */
package rob_pkg;

    // walk lasts from the cycle after a flush until the last entry is popped
    typedef enum logic [1:0] {
        ROB_IDLE = 2'b00,
        ROB_WALK = 2'b01
    } rob_state_e;

endpackage

/* source/uop_pkg.sv */
package uop_pkg;

    // integer alu operations
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,  ALU_SUB  = 4'd1,  ALU_AND = 4'd2,
        ALU_OR   = 4'd3,  ALU_XOR  = 4'd4,  ALU_SLT = 4'd5,
        ALU_SLTU = 4'd6,  ALU_SLL  = 4'd7,  ALU_SRL = 4'd8,
        ALU_SRA  = 4'd9,  ALU_LUI  = 4'd10
    } alu_type_e;

    // branch and jump kinds
    typedef enum logic [2:0] {
        CX_NONE = 3'd0,  CX_BEQ = 3'd1,  CX_BNE  = 3'd2,
        CX_BLT  = 3'd3,  CX_BGE = 3'd4,  CX_JAL  = 3'd5,
        CX_JALR = 3'd6
    } cx_type_e;

    typedef enum logic [2:0] {
        MD_NONE = 3'd0,  MD_MUL = 3'd1,  MD_MULH = 3'd2,
        MD_DIV  = 3'd3,  MD_REM = 3'd4
    } muldiv_type_e;

endpackage

/* source/backend_macros.svh */
`ifndef BACKEND_MACROS_SVH
`define BACKEND_MACROS_SVH

// register and pc widths
`define PC_RANGE        63:0
`define LREG_RANGE      4:0
`define PREG_RANGE      5:0
`define PREG_NUM        64

// queue sizes
`define ROB_DEPTH       16
`define INSTR_ID_WIDTH  4       // log2 of ROB_DEPTH
`define ISQ_DEPTH       8

`endif
